// ==== include/s16_settings.svh ====
/*
 * System 16B main bus settings
 * CPU clock-enable ratio and reset values of the region map
 */
`ifndef S16_SETTINGS_SVH
`define S16_SETTINGS_SVH

// 68000 enable out of the system clock, 29 pulses every 146 clocks
`define S16_CEN_NUM 8'd29
`define S16_CEN_DEN 8'd146

`define S16_REGIONS 8

// Base bytes, compared against A[23:16]
`define S16_BASE_0 8'h00
`define S16_BASE_1 8'h01
`define S16_BASE_2 8'h02
`define S16_BASE_3 8'hff
`define S16_BASE_4 8'h40
`define S16_BASE_5 8'h44
`define S16_BASE_6 8'h84
`define S16_BASE_7 8'hc4

// Size masks. Video RAM spans two 64kB pages, text and tiles
`define S16_MASK_0 8'hff
`define S16_MASK_1 8'hff
`define S16_MASK_2 8'hff
`define S16_MASK_3 8'hff
`define S16_MASK_4 8'hfe
`define S16_MASK_5 8'hff
`define S16_MASK_6 8'hff
`define S16_MASK_7 8'hff

`endif

// ==== hw/s16_bus_pkg.sv ====
/*
 * System 16B CPU bus types
 * 68000 bus request, two decodings of the word address, region indices
 */
package s16_bus_pkg;

    // One 68000 bus cycle as seen from the master
    typedef struct packed {
        logic        asn;
        logic        rnw;
        logic        udsn;
        logic        ldsn;
        logic [2:0]  fc;
        logic [23:1] addr;
        logic [15:0] wdata;
    } bus_req_t;

    // Cabinet I/O register selection
    typedef struct packed {
        logic [23:14] upper;
        logic [13:12] page;
        logic [11:3]  mid;
        logic [2:1]   regsel;
    } io_view_t;

    // Video RAM page, bit 16 picks character RAM
    typedef struct packed {
        logic [23:17] upper;
        logic         bank;
        logic [15:1]  offset;
    } vram_view_t;

    typedef union packed {
        io_view_t   io;
        vram_view_t vram;
    } addr_view_u;

    // Regions 0 to 2 are program ROM
    localparam logic [2:0] REG_RAM  = 3'd3;
    localparam logic [2:0] REG_VRAM = 3'd4;
    localparam logic [2:0] REG_ORAM = 3'd5;
    localparam logic [2:0] REG_PAL  = 3'd6;
    localparam logic [2:0] REG_IO   = 3'd7;

endpackage

// ==== hw/s16_io_pkg.sv ====
/*
 * System 16B cabinet types
 * Player controls, coin and service inputs, DIP switch banks
 */
package s16_io_pkg;

    // Raw cabinet inputs as wired on the edge connector
    typedef struct packed {
        logic [7:0] joy1;
        logic [7:0] joy2;
        logic [1:0] start;
        logic [1:0] coin;
        logic       service;
        logic       test;
        logic       pause;
    } cab_in_t;

    // Two 8-position DIP banks
    typedef struct packed {
        logic [7:0] b;
        logic [7:0] a;
    } dip_t;

endpackage

// ==== hw/s16_mapper.sv ====
/*
 * System 16B region mapper
 * Eight programmable base comparators on A[23:16], lowest region wins
 */
`timescale 1ns/10ps
`include "s16_settings.svh"

module s16_mapper (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    map_we,
    input  logic [2:0]              map_idx,
    input  logic [7:0]              map_base,
    input  logic [23:1]             addr,
    output logic [`S16_REGIONS-1:0] active
);

    localparam logic [7:0] BASE_RST [`S16_REGIONS] = '{
        `S16_BASE_0, `S16_BASE_1, `S16_BASE_2, `S16_BASE_3,
        `S16_BASE_4, `S16_BASE_5, `S16_BASE_6, `S16_BASE_7
    };

    localparam logic [7:0] SIZE_MASK [`S16_REGIONS] = '{
        `S16_MASK_0, `S16_MASK_1, `S16_MASK_2, `S16_MASK_3,
        `S16_MASK_4, `S16_MASK_5, `S16_MASK_6, `S16_MASK_7
    };

    logic [7:0]              base_q [`S16_REGIONS];
    logic [`S16_REGIONS-1:0] match;

    // Base registers, written by the bus controller
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `S16_REGIONS; i++) begin
                base_q[i] <= BASE_RST[i];
            end
        end else if (map_we) begin
            base_q[map_idx] <= map_base;
        end
    end

    // Masked compare of the top address byte
    always_comb begin
        for (int i = 0; i < `S16_REGIONS; i++) begin
            match[i] = ((addr[23:16] ^ base_q[i]) & SIZE_MASK[i]) == 8'h00;
        end
    end

    // Walk down so the lowest matching region is the one left standing
    always_comb begin
        active = '0;
        for (int i = `S16_REGIONS - 1; i >= 0; i--) begin
            if (match[i]) begin
                active    = '0;
                active[i] = 1'b1;
            end
        end
    end

endmodule

// ==== hw/s16_bus_decode.sv ====
/*
 * System 16B chip select decoder
 * Registered chip selects, memory wait condition and the CPU read mux
 */
`timescale 1ns/10ps
`include "s16_settings.svh"

module s16_bus_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  s16_bus_pkg::bus_req_t   bus_req,
    input  logic [`S16_REGIONS-1:0] active,
    input  logic [7:0]              cab_dout,
    input  logic [15:0]             rom_data,
    input  logic                    rom_ok,
    input  logic [15:0]             ram_data,
    input  logic                    ram_ok,
    input  logic [15:0]             char_dout,
    input  logic [15:0]             pal_dout,
    input  logic [15:0]             obj_dout,
    output logic                    rom_cs,
    output logic                    ram_cs,
    output logic                    vram_cs,
    output logic                    char_cs,
    output logic                    pal_cs,
    output logic                    objram_cs,
    output logic                    io_cs,
    output logic                    bus_cs,
    output logic                    bus_busy,
    output logic [15:0]             rdata,
    output logic [18:1]             rom_addr
);

    s16_bus_pkg::addr_view_u av;
    logic                    access;
    logic                    strobe;

    assign av = bus_req.addr;

    // CPU space cycles (interrupt acknowledge) never reach memory
    assign access = !bus_req.asn && (bus_req.fc != 3'b111);
    assign strobe = !(bus_req.udsn && bus_req.ldsn);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
        end else if (access) begin
            rom_cs    <= |active[2:0];
            char_cs   <= active[s16_bus_pkg::REG_VRAM] && av.vram.bank;
            objram_cs <= active[s16_bus_pkg::REG_ORAM];
            pal_cs    <= active[s16_bus_pkg::REG_PAL];
            io_cs     <= active[s16_bus_pkg::REG_IO];
            // SDRAM side needs a fresh select per strobe
            vram_cs   <= strobe && active[s16_bus_pkg::REG_VRAM] && !av.vram.bank;
            ram_cs    <= strobe && active[s16_bus_pkg::REG_RAM];
        end else begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
        end
    end

    assign bus_cs   = rom_cs | ram_cs | vram_cs | char_cs | pal_cs | objram_cs | io_cs;
    assign bus_busy = (rom_cs & ~rom_ok) | ((ram_cs | vram_cs) & ~ram_ok);
    assign rom_addr = bus_req.addr[18:1];

    // Read data, held on unmapped accesses
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= 16'hffff;
        end else if (ram_cs || vram_cs) begin
            rdata <= ram_data;
        end else if (rom_cs) begin
            rdata <= rom_data;
        end else if (char_cs) begin
            rdata <= char_dout;
        end else if (pal_cs) begin
            rdata <= pal_dout;
        end else if (objram_cs) begin
            rdata <= obj_dout;
        end else if (io_cs) begin
            rdata <= {8'hff, cab_dout};
        end
    end

endmodule

// ==== hw/s16_cab_io.sv ====
/*
 * System 16B cabinet I/O
 * Player input and DIP read port, screen flip latch
 */
`timescale 1ns/10ps

module s16_cab_io (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  io_cs,
    input  s16_bus_pkg::bus_req_t bus_req,
    input  s16_io_pkg::cab_in_t   cab,
    input  s16_io_pkg::dip_t      dip,
    output logic [7:0]            cab_dout,
    output logic                  flip
);

    s16_bus_pkg::addr_view_u av;

    assign av = bus_req.addr;

    // Board wiring of the joystick bits
    function automatic logic [7:0] sort_joy(input logic [7:0] joy);
        return {joy[1:0], joy[3:2], joy[7], joy[5:4], joy[6]};
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cab_dout <= 8'hff;
            flip     <= 1'b0;
        end else begin
            cab_dout <= 8'hff;
            if (io_cs) begin
                case (av.io.page)
                    2'd0: begin
                        // Only a low byte write reaches the latch
                        if (!bus_req.rnw && !bus_req.ldsn) begin
                            flip <= bus_req.wdata[6];
                        end
                    end
                    2'd1: begin
                        case (av.io.regsel)
                            2'd0: cab_dout <= {2'b11, cab.start, cab.service, cab.test, cab.coin};
                            2'd1: cab_dout <= sort_joy(cab.joy1);
                            2'd3: cab_dout <= sort_joy(cab.joy2);
                            default: cab_dout <= 8'hff;
                        endcase
                    end
                    2'd2: cab_dout <= av.io.regsel[1] ? dip.b : dip.a;
                    default: cab_dout <= 8'hff;
                endcase
            end
        end
    end

endmodule

// ==== hw/s16_dtack.sv ====
/*
 * 68000 clock enables and DTACK
 * Fractional 29/146 enable pair, DTACK held off while memory is busy
 */
`timescale 1ns/10ps
`include "s16_settings.svh"

module s16_dtack (
    input  logic                  clk,
    input  logic                  rst,
    input  s16_bus_pkg::bus_req_t bus_req,
    input  logic                  bus_cs,
    input  logic                  bus_busy,
    output logic                  cpu_cen,
    output logic                  cpu_cenb,
    output logic                  dtackn
);

    typedef enum logic [1:0] {S_IDLE, S_WAIT, S_ACK} state_t;

    // Double step, odd overflows become cen and even ones cenb
    localparam logic [8:0] STEP = {`S16_CEN_NUM, 1'b0};
    localparam logic [8:0] DEN  = {1'b0, `S16_CEN_DEN};

    logic [8:0] acc;
    logic [8:0] sum;
    logic       half;
    state_t     state;
    logic       cs_dly;
    logic       dtack_q;
    logic       bus_n;

    assign sum   = acc + STEP;
    assign bus_n = bus_req.asn | (bus_req.udsn & bus_req.ldsn);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc      <= '0;
            half     <= 1'b0;
            cpu_cen  <= 1'b0;
            cpu_cenb <= 1'b0;
        end else begin
            cpu_cen  <= 1'b0;
            cpu_cenb <= 1'b0;
            if (sum >= DEN) begin
                acc  <= sum - DEN;
                half <= ~half;
                if (half) begin
                    cpu_cenb <= 1'b1;
                end else begin
                    cpu_cen <= 1'b1;
                end
            end else begin
                acc <= sum;
            end
        end
    end

    // cs_dly makes sure a select has been up a full clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= S_IDLE;
            cs_dly  <= 1'b0;
            dtack_q <= 1'b1;
        end else begin
            cs_dly <= bus_cs;
            case (state)
                S_IDLE: begin
                    dtack_q <= 1'b1;
                    if (!bus_n) state <= S_WAIT;
                end
                S_WAIT: begin
                    if (bus_req.asn) begin
                        state <= S_IDLE;
                    end else if (cpu_cen && bus_cs && cs_dly && !bus_busy) begin
                        dtack_q <= 1'b0;
                        state   <= S_ACK;
                    end
                end
                default: begin
                    if (bus_req.asn) begin
                        dtack_q <= 1'b1;
                        state   <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // Released on the first clock after the master lets go of AS
    assign dtackn = dtack_q;

endmodule

// ==== hw/s16_main_bus.sv ====
/*
 * System 16B main CPU bus glue
 * Region mapper, chip select decoder, cabinet I/O and DTACK
 */
`timescale 1ns/10ps
`include "s16_settings.svh"

module s16_main_bus (
    input  logic                  clk,
    input  logic                  rst,
    input  s16_bus_pkg::bus_req_t bus_req,
    input  logic                  map_we,
    input  logic [2:0]            map_idx,
    input  logic [7:0]            map_base,
    input  s16_io_pkg::cab_in_t   cab,
    input  s16_io_pkg::dip_t      dip,
    input  logic [15:0]           rom_data,
    input  logic                  rom_ok,
    input  logic [15:0]           ram_data,
    input  logic                  ram_ok,
    input  logic [15:0]           char_dout,
    input  logic [15:0]           pal_dout,
    input  logic [15:0]           obj_dout,
    output logic                  rom_cs,
    output logic                  ram_cs,
    output logic                  vram_cs,
    output logic                  char_cs,
    output logic                  pal_cs,
    output logic                  objram_cs,
    output logic                  io_cs,
    output logic [18:1]           rom_addr,
    output logic [15:0]           rdata,
    output logic                  dtackn,
    output logic                  cpu_cen,
    output logic                  flip
);

    logic [`S16_REGIONS-1:0] active;
    logic [7:0]              cab_dout;
    logic                    bus_cs;
    logic                    bus_busy;

    s16_mapper u_mapper (
        .clk      ( clk          ),
        .rst      ( rst          ),
        .map_we   ( map_we       ),
        .map_idx  ( map_idx      ),
        .map_base ( map_base     ),
        .addr     ( bus_req.addr ),
        .active   ( active       )
    );

    s16_bus_decode u_decode (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .bus_req   ( bus_req   ),
        .active    ( active    ),
        .cab_dout  ( cab_dout  ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .ram_data  ( ram_data  ),
        .ram_ok    ( ram_ok    ),
        .char_dout ( char_dout ),
        .pal_dout  ( pal_dout  ),
        .obj_dout  ( obj_dout  ),
        .rom_cs    ( rom_cs    ),
        .ram_cs    ( ram_cs    ),
        .vram_cs   ( vram_cs   ),
        .char_cs   ( char_cs   ),
        .pal_cs    ( pal_cs    ),
        .objram_cs ( objram_cs ),
        .io_cs     ( io_cs     ),
        .bus_cs    ( bus_cs    ),
        .bus_busy  ( bus_busy  ),
        .rdata     ( rdata     ),
        .rom_addr  ( rom_addr  )
    );

    s16_cab_io u_cab_io (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .io_cs    ( io_cs    ),
        .bus_req  ( bus_req  ),
        .cab      ( cab      ),
        .dip      ( dip      ),
        .cab_dout ( cab_dout ),
        .flip     ( flip     )
    );

    // Only the rising-phase enable leaves the block
    s16_dtack u_dtack (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .bus_req  ( bus_req  ),
        .bus_cs   ( bus_cs   ),
        .bus_busy ( bus_busy ),
        .cpu_cen  ( cpu_cen  ),
        .cpu_cenb (          ),
        .dtackn   ( dtackn   )
    );

endmodule

// ==== verification/s16_main_bus_sva.sv ====
/*
 * Bus protocol assertions for the main bus glue
 * Chip select exclusivity, reset state and DTACK rules
 */
`timescale 1ns/10ps

module s16_main_bus_sva (
    input logic                  clk,
    input logic                  rst,
    input s16_bus_pkg::bus_req_t bus_req,
    input logic [6:0]            cs,
    input logic                  dtackn,
    input logic                  bus_busy
);

    cs_exclusive: assert property (@(posedge clk) disable iff (rst) $onehot0(cs))
        else $error("more than one chip select high: %b", cs);

    // No acknowledge outside a cycle
    dtack_needs_as: assert property (@(posedge clk) disable iff (rst) bus_req.asn |=> dtackn)
        else $error("DTACK still low a clock after AS went high");

    cs_in_reset: assert property (@(posedge clk) rst |-> (cs == 7'd0))
        else $error("chip select high during reset: %b", cs);

    // Slow memory holds off the acknowledge
    dtack_waits: assert property (@(posedge clk) disable iff (rst) bus_busy |-> dtackn)
        else $error("DTACK low while memory is busy");

endmodule

bind s16_main_bus s16_main_bus_sva sva_inst (
    .clk      ( clk      ),
    .rst      ( rst      ),
    .bus_req  ( bus_req  ),
    .cs       ( {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, io_cs} ),
    .dtackn   ( dtackn   ),
    .bus_busy ( bus_busy )
);

// ==== verification/s16_main_bus_tb.sv ====
/*
 * Testbench for the System 16B main bus glue
 * Plays the 68000 master, models the memories and checks against a reference decoder
 */
`timescale 1ns/10ps
`include "s16_settings.svh"

module s16_main_bus_tb;

    // Chip select order is rom, ram, vram, char, pal, obj, io
    typedef struct packed {
        logic [6:0]  cs;
        logic [15:0] data;
    } expect_t;

    localparam logic [7:0] DEF_BASE [8] = '{
        `S16_BASE_0, `S16_BASE_1, `S16_BASE_2, `S16_BASE_3,
        `S16_BASE_4, `S16_BASE_5, `S16_BASE_6, `S16_BASE_7
    };
    localparam logic [7:0] SIZE_MASK [8] = '{
        `S16_MASK_0, `S16_MASK_1, `S16_MASK_2, `S16_MASK_3,
        `S16_MASK_4, `S16_MASK_5, `S16_MASK_6, `S16_MASK_7
    };
    localparam int WAIT_LIMIT = 200;

    logic                  clk;
    logic                  rst;
    s16_bus_pkg::bus_req_t bus_req;
    logic                  map_we;
    logic [2:0]            map_idx;
    logic [7:0]            map_base;
    s16_io_pkg::cab_in_t   cab;
    s16_io_pkg::dip_t      dip;
    logic [15:0]           rom_data;
    logic                  rom_ok;
    logic [15:0]           ram_data;
    logic                  ram_ok;
    logic [15:0]           char_dout;
    logic [15:0]           pal_dout;
    logic [15:0]           obj_dout;
    logic                  rom_cs;
    logic                  ram_cs;
    logic                  vram_cs;
    logic                  char_cs;
    logic                  pal_cs;
    logic                  objram_cs;
    logic                  io_cs;
    logic [18:1]           rom_addr;
    logic [15:0]           rdata;
    logic                  dtackn;
    logic                  cpu_cen;
    logic                  flip;

    logic [6:0]  cs_vec;
    logic [7:0]  base_tbl [8];
    logic [23:1] mem_addr;
    logic [18:1] rom_word;
    logic [15:0] last_data;
    int          rom_delay;
    int          ram_delay;
    int          rom_cnt;
    int          ram_cnt;
    int          cen_count;

    assign cs_vec = {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, io_cs};

    s16_main_bus s16_main_bus_inst (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Memory contents fold in every address bit
    function automatic logic [15:0] fill_word(input logic [23:1] a, input logic [15:0] salt);
        return a[16:1] ^ {a[23:17], a[23:21], a[18:13]} ^ salt;
    endfunction

    // Memory models, slow ones raise ok after the chosen delay
    always @(posedge clk) begin
        mem_addr = bus_req.addr;
        rom_word = rom_addr;
        #1;
        rom_data  = fill_word({5'd0, rom_word}, 16'h1357);
        ram_data  = fill_word(mem_addr, vram_cs ? 16'h9abc : 16'h2468);
        char_dout = fill_word(mem_addr, 16'hc3c3);
        pal_dout  = fill_word(mem_addr, 16'h5a0f);
        obj_dout  = fill_word(mem_addr, 16'h0ff0);
        if (!rom_cs) begin
            rom_cnt = 0;
            rom_ok  = 1'b0;
        end else if (rom_cnt >= rom_delay) begin
            rom_ok = 1'b1;
        end else begin
            rom_cnt++;
        end
        if (!(ram_cs || vram_cs)) begin
            ram_cnt = 0;
            ram_ok  = 1'b0;
        end else if (ram_cnt >= ram_delay) begin
            ram_ok = 1'b1;
        end else begin
            ram_cnt++;
        end
    end

    function automatic logic [7:0] joy_sorted(input logic [7:0] j);
        return {j[1:0], j[3:2], j[7], j[5:4], j[6]};
    endfunction

    // Cabinet byte by page (A13:12) and register (A2:1)
    function automatic logic [7:0] cab_byte(input logic [23:1] a);
        logic [7:0] b;
        b = 8'hff;
        if (a[13:12] == 2'd1) begin
            case (a[2:1])
                2'd0:    b = {2'b11, cab.start, cab.service, cab.test, cab.coin};
                2'd1:    b = joy_sorted(cab.joy1);
                2'd3:    b = joy_sorted(cab.joy2);
                default: b = 8'hff;
            endcase
        end else if (a[13:12] == 2'd2) begin
            b = a[1] ? dip.b : dip.a;
        end
        return b;
    endfunction

    function automatic expect_t expected_result(input logic [23:1] a);
        expect_t e;
        int      region;
        region = -1;
        e.cs   = 7'd0;
        e.data = 16'hffff;
        // Lowest matching region wins
        for (int i = 7; i >= 0; i--) begin
            if (((a[23:16] ^ base_tbl[i]) & SIZE_MASK[i]) == 8'h00) begin
                region = i;
            end
        end
        case (region)
            0, 1, 2: begin
                e.cs   = 7'b1000000;
                e.data = fill_word({5'd0, a[18:1]}, 16'h1357);
            end
            3: begin
                e.cs   = 7'b0100000;
                e.data = fill_word(a, 16'h2468);
            end
            4: begin
                e.cs   = a[16] ? 7'b0001000 : 7'b0010000;
                e.data = fill_word(a, a[16] ? 16'hc3c3 : 16'h9abc);
            end
            5: begin
                e.cs   = 7'b0000010;
                e.data = fill_word(a, 16'h0ff0);
            end
            6: begin
                e.cs   = 7'b0000100;
                e.data = fill_word(a, 16'h5a0f);
            end
            7: begin
                e.cs   = 7'b0000001;
                e.data = {8'hff, cab_byte(a)};
            end
            default: ;
        endcase
        return e;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_cs(input string name, input logic [6:0] exp, input logic [6:0] act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
        end
    endtask

    // Starts a cycle with fresh memory delays and cabinet inputs
    task automatic drive_cycle(input logic [23:1] a, input logic rnw, input logic [1:0] dsn,
                               input logic [15:0] wd);
        logic [31:0] rnd;
        rom_delay = $urandom % 8;
        ram_delay = $urandom % 8;
        @(posedge clk);
        #1;
        rnd           = $urandom;
        cab           = rnd[22:0];
        rnd           = $urandom;
        dip           = rnd[15:0];
        bus_req.addr  = a;
        bus_req.rnw   = rnw;
        bus_req.fc    = 3'b101;
        bus_req.wdata = wd;
        bus_req.udsn  = dsn[1];
        bus_req.ldsn  = dsn[0];
        bus_req.asn   = 1'b0;
    endtask

    task automatic wait_dtack(input string name);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !seen; i++) begin
            @(negedge clk);
            seen = !dtackn;
        end
        if (!seen) begin
            fail_run($sformatf("%s: no DTACK within %0d clocks", name, WAIT_LIMIT));
        end
    endtask

    task automatic end_cycle();
        @(posedge clk);
        #1;
        bus_req.asn  = 1'b1;
        bus_req.udsn = 1'b1;
        bus_req.ldsn = 1'b1;
        bus_req.rnw  = 1'b1;
        @(posedge clk);
    endtask

    task automatic read_check(input string name, input logic [23:1] a);
        expect_t e;
        drive_cycle(a, 1'b1, 2'b00, 16'h0000);
        e = expected_result(a);
        wait_dtack(name);
        check_cs(name, e.cs, cs_vec);
        if ((rom_cs && !rom_ok) || ((ram_cs || vram_cs) && !ram_ok)) begin
            fail_run($sformatf("%s: DTACK came before the memory was ready", name));
        end
        check_word(name, e.data, rdata);
        last_data = e.data;
        end_cycle();
    endtask

    task automatic write_cycle(input string name, input logic [23:1] a, input logic [1:0] dsn,
                               input logic [15:0] wd);
        drive_cycle(a, 1'b0, dsn, wd);
        wait_dtack(name);
        end_cycle();
    endtask

    task automatic program_base(input logic [2:0] idx, input logic [7:0] base);
        @(posedge clk);
        #1;
        map_we   = 1'b1;
        map_idx  = idx;
        map_base = base;
        @(posedge clk);
        #1;
        map_we        = 1'b0;
        base_tbl[idx] = base;
    endtask

    function automatic logic [23:1] region_addr(input int r);
        logic [31:0] rnd;
        rnd = $urandom;
        return {base_tbl[r] ^ (rnd[23:16] & ~SIZE_MASK[r]), rnd[15:1]};
    endfunction

    task automatic random_reads(input string name, input int count);
        int r;
        for (int n = 0; n < count; n++) begin
            r = $urandom % 8;
            read_check($sformatf("%s_%0d", name, n), region_addr(r));
        end
    endtask

    initial begin
        expect_t e;
        void'($urandom(32'ha29d_2ee3));
        rst       = 1'b1;
        map_we    = 1'b0;
        map_idx   = 3'd0;
        map_base  = 8'h00;
        cab       = '0;
        dip       = '0;
        bus_req   = '0;
        bus_req.asn  = 1'b1;
        bus_req.rnw  = 1'b1;
        bus_req.udsn = 1'b1;
        bus_req.ldsn = 1'b1;
        rom_data  = 16'h0000;
        ram_data  = 16'h0000;
        char_dout = 16'h0000;
        pal_dout  = 16'h0000;
        obj_dout  = 16'h0000;
        rom_ok    = 1'b0;
        ram_ok    = 1'b0;
        rom_delay = 0;
        ram_delay = 0;
        last_data = 16'hffff;
        for (int i = 0; i < 8; i++) begin
            base_tbl[i] = DEF_BASE[i];
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        check_cs("reset_cs", 7'd0, cs_vec);
        check_word("reset_rdata", 16'hffff, rdata);
        check_word("reset_flip", 16'h0000, {15'd0, flip});
        check_word("reset_dtackn", 16'h0001, {15'd0, dtackn});

        // 68000 enable rate over one full accumulator period
        cen_count = 0;
        for (int i = 0; i < 146; i++) begin
            @(negedge clk);
            cen_count += int'(cpu_cen);
        end
        check_word("cen_rate", 16'd29, cen_count[15:0]);

        random_reads("decode", 96);

        // Every page and register of the cabinet port, three passes
        for (int n = 0; n < 48; n++) begin
            read_check($sformatf("cab_%0d", n),
                       {base_tbl[7], 2'b00, n[3:2], 9'd0, n[1:0]});
        end

        write_cycle("flip_set", {base_tbl[7], 15'd0}, 2'b10, 16'h0040);
        check_word("flip_set", 16'h0001, {15'd0, flip});
        write_cycle("flip_upper", {base_tbl[7], 15'd0}, 2'b01, 16'h0000);
        check_word("flip_upper", 16'h0001, {15'd0, flip});
        write_cycle("flip_clear", {base_tbl[7], 15'd0}, 2'b10, 16'hffbf);
        check_word("flip_clear", 16'h0000, {15'd0, flip});

        program_base(3'd0, 8'h10);
        program_base(3'd1, 8'h11);
        program_base(3'd2, 8'h12);
        program_base(3'd3, 8'h20);
        program_base(3'd4, 8'h60);
        program_base(3'd5, 8'h70);
        program_base(3'd6, 8'h90);
        program_base(3'd7, 8'hd0);
        random_reads("remap", 96);

        // Nothing sits at 0x33 so the cycle must hang without DTACK
        e = expected_result({8'h33, 15'h1234});
        if (e.cs != 7'd0) begin
            fail_run("unmapped test address falls inside a region");
        end
        drive_cycle({8'h33, 15'h1234}, 1'b1, 2'b00, 16'h0000);
        for (int i = 0; i < 64; i++) begin
            @(negedge clk);
            check_cs("unmapped_cs", 7'd0, cs_vec);
            if (!dtackn) begin
                fail_run("unmapped read was acknowledged");
            end
        end
        end_cycle();
        check_word("unmapped_hold", last_data, rdata);
        read_check("after_unmapped", region_addr(3));

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
hw/s16_bus_pkg.sv
hw/s16_io_pkg.sv
hw/s16_mapper.sv
hw/s16_bus_decode.sv
hw/s16_cab_io.sv
hw/s16_dtack.sv
hw/s16_main_bus.sv
verification/s16_main_bus_sva.sv
verification/s16_main_bus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the main bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module s16_main_bus_tb -f sim.f -o s16_main_bus_sim

status=0
./obj_dir/s16_main_bus_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q ">>> FAIL" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
echo "simulation finished without failures"
